/* hw/muldiv_settings.svh */
`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// result tags name up to 64 instructions in flight
`define MULDIV_TAG_W 6

// operands and results are one machine word
`define MULDIV_DATA_W 32

// entries held by each execution queue
`define MULDIV_QUEUE_DEPTH 4

// the restoring divider produces one quotient bit per iteration
`define MULDIV_DIV_STEPS 32

// register stages between multiplier issue and its result
`define MULDIV_MUL_STAGES 3

`endif

/* hw/muldiv_pkg.sv */
`include "muldiv_settings.svh"

package muldiv_pkg;

   // a tag names a result that has not reached the CDB yet
   typedef logic [`MULDIV_TAG_W-1:0] tag_t;

   // operands and results share one width
   typedef logic [`MULDIV_DATA_W-1:0] data_t;

   // the operation class picks the execution queue at dispatch
   typedef enum logic {
      OP_MUL = 1'b0,
      OP_DIV = 1'b1
   } muldiv_op_t;

endpackage

/* hw/exec_queue.sv */
`timescale 1ns/10ps
`include "muldiv_settings.svh"

module exec_queue
   import muldiv_pkg::*;
#(
   parameter int DEPTH = `MULDIV_QUEUE_DEPTH
) (
   input  logic  clk,
   input  logic  rst_n,

   input  tag_t  rdtag,
   input  tag_t  rstag,
   input  tag_t  rttag,
   input  data_t rsdata,
   input  data_t rtdata,
   input  logic  rsvalid,
   input  logic  rtvalid,
   input  logic  en,
   output logic  ready,

   input  logic  cdb_valid,
   input  tag_t  cdb_tag,
   input  data_t cdb_data,

   output logic  issue_valid,
   output tag_t  issue_rdtag,
   output data_t issue_rsdata,
   output data_t issue_rtdata,
   input  logic  issue_accept
);

   // one waiting instruction
   // an operand flagged valid holds its value, otherwise its tag names the producer
   typedef struct packed {
      tag_t  rdtag;
      tag_t  rstag;
      tag_t  rttag;
      logic  rsvalid;
      logic  rtvalid;
      data_t rsdata;
      data_t rtdata;
   } entry_t;

   // slot 0 is the oldest entry and occupied slots are always contiguous from 0
   logic [DEPTH-1:0] valid_q;
   logic [DEPTH-1:0] valid_n;
   entry_t           slot_q [DEPTH];
   entry_t           slot_n [DEPTH];

   // slots after CDB capture, with an extra empty slot on top to shift from
   logic [DEPTH:0]   valid_c;
   entry_t           slot_c [DEPTH+1];
   entry_t           incoming;

   logic [DEPTH-1:0] entry_rdy;
   logic [DEPTH-1:0] sel_oh;
   logic [DEPTH-1:0] shift;
   entry_t           sel_entry;
   logic             issue_fire;
   logic             push;

   // an operand that is still waiting takes the CDB value when the tags match
   function automatic entry_t snoop(entry_t e, logic cv, tag_t ct, data_t cd);
      entry_t r;
      r = e;
      if (cv && !e.rsvalid && e.rstag == ct) begin
         r.rsvalid = 1'b1;
         r.rsdata  = cd;
      end
      if (cv && !e.rtvalid && e.rttag == ct) begin
         r.rtvalid = 1'b1;
         r.rtdata  = cd;
      end
      return r;
   endfunction

   always_comb begin
      // the instruction being dispatched snoops too, so a result broadcast in
      // its dispatch cycle is not missed
      incoming = '{rdtag: rdtag, rstag: rstag, rttag: rttag, rsvalid: rsvalid,
                   rtvalid: rtvalid, rsdata: rsdata, rtdata: rtdata};
      incoming = snoop(incoming, cdb_valid, cdb_tag, cdb_data);
      for (int i = 0; i < DEPTH; i++) begin
         slot_c[i] = snoop(slot_q[i], cdb_valid, cdb_tag, cdb_data);
      end
      slot_c[DEPTH] = '0;
      valid_c       = {1'b0, valid_q};
   end

   // readiness looks at registered operands only
   // so a CDB capture makes an entry ready one cycle after the broadcast
   always_comb begin : pick_oldest
      logic found;
      found     = 1'b0;
      sel_oh    = '0;
      sel_entry = slot_q[0];
      for (int i = 0; i < DEPTH; i++) begin
         entry_rdy[i] = valid_q[i] && slot_q[i].rsvalid && slot_q[i].rtvalid;
         // the lowest ready slot is the oldest ready instruction
         if (entry_rdy[i] && !found) begin
            found     = 1'b1;
            sel_oh[i] = 1'b1;
            sel_entry = slot_q[i];
         end
      end
   end

   assign issue_valid  = |entry_rdy;
   assign issue_rdtag  = sel_entry.rdtag;
   assign issue_rsdata = sel_entry.rsdata;
   assign issue_rtdata = sel_entry.rtdata;
   assign issue_fire   = issue_valid && issue_accept;

   // the issued slot and every slot above it move down by one
   assign shift = issue_fire ? ~(sel_oh - DEPTH'(1)) : '0;

   // a full queue still takes an entry when one leaves in the same cycle
   assign ready = !valid_q[DEPTH-1] || issue_fire;
   assign push  = en && ready;

   always_comb begin : collapse
      logic placed;
      placed = 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
         valid_n[i] = shift[i] ? valid_c[i+1] : valid_c[i];
         slot_n[i]  = shift[i] ? slot_c[i+1] : slot_c[i];
         // the new entry lands on the first free slot above the survivors
         if (push && !valid_n[i] && !placed) begin
            placed     = 1'b1;
            valid_n[i] = 1'b1;
            slot_n[i]  = incoming;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
      end else begin
         valid_q <= valid_n;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         slot_q[i] <= slot_n[i];
      end
   end

   // dispatch has to honour back-pressure from this queue
   a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      en |-> ready)
      else $error("exec_queue: dispatch while full");

   // an issued entry never carries an operand still waiting on the CDB
   a_issue_operands: assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid |-> sel_entry.rsvalid && sel_entry.rtvalid)
      else $error("exec_queue: issue with a pending operand");

endmodule

/* hw/mul_unit.sv */
`timescale 1ns/10ps
`include "muldiv_settings.svh"

module mul_unit
   import muldiv_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  issue_valid,
   input  tag_t  issue_rdtag,
   input  data_t issue_rsdata,
   input  data_t issue_rtdata,
   output logic  issue_accept,
   output logic  result_valid,
   output tag_t  result_tag,
   output data_t result_data,
   input  logic  result_grant
);

   localparam int STAGES = `MULDIV_MUL_STAGES;
   localparam int W      = $bits(data_t);
   localparam int H      = W / 2;

   // the datapath below has exactly three register stages
   if (STAGES != 3) begin : g_stage_check
      $error("mul_unit expects three pipeline stages");
   end

   // one valid bit per stage, the top bit faces the CDB arbiter
   logic [STAGES-1:0] vld_q;
   logic              advance;

   // stage 1 holds the operands
   data_t        a_q;
   data_t        b_q;
   tag_t         tag1_q;
   // stage 2 holds the partial products
   data_t        low_q;
   logic [H-1:0] cross_q;
   tag_t         tag2_q;
   // stage 3 holds the low word of the product
   data_t        prod_q;
   tag_t         tag3_q;

   data_t        low_n;
   logic [H-1:0] cross_n;

   // the whole pipeline freezes while its finished result waits for the CDB
   assign advance      = !vld_q[STAGES-1] || result_grant;
   assign issue_accept = advance;

   // only the low word is kept, so the high by high product is never needed
   // and the cross terms only matter in their low half
   always_comb begin
      low_n   = data_t'(a_q[H-1:0]) * data_t'(b_q[H-1:0]);
      cross_n = a_q[H-1:0] * b_q[W-1:H] + a_q[W-1:H] * b_q[H-1:0];
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q <= '0;
      end else if (advance) begin
         vld_q <= {vld_q[STAGES-2:0], issue_valid};
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         a_q     <= issue_rsdata;
         b_q     <= issue_rtdata;
         tag1_q  <= issue_rdtag;
         low_q   <= low_n;
         cross_q <= cross_n;
         tag2_q  <= tag1_q;
         prod_q  <= low_q + {cross_q, {H{1'b0}}};
         tag3_q  <= tag2_q;
      end
   end

   assign result_valid = vld_q[STAGES-1];
   assign result_tag   = tag3_q;
   assign result_data  = prod_q;

   // a stalled result stays put until the arbiter takes it
   a_hold_result: assert property (@(posedge clk) disable iff (!rst_n)
      result_valid && !result_grant |=>
         result_valid && $stable(result_data) && $stable(result_tag))
      else $error("mul_unit: result changed before grant");

endmodule

/* hw/div_unit.sv */
`timescale 1ns/10ps
`include "muldiv_settings.svh"

module div_unit
   import muldiv_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  issue_valid,
   input  tag_t  issue_rdtag,
   input  data_t issue_rsdata,
   input  data_t issue_rtdata,
   output logic  issue_accept,
   output logic  result_valid,
   output tag_t  result_tag,
   output data_t result_data,
   input  logic  result_grant
);

   localparam int               STEPS     = `MULDIV_DIV_STEPS;
   localparam int               W         = $bits(data_t);
   localparam int               CNT_W     = $clog2(STEPS);
   localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(STEPS - 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BUSY,
      ST_DONE
   } state_t;

   state_t           state_q;
   logic [CNT_W-1:0] step_q;
   logic             start;

   // the quotient register starts out holding the dividend
   // and its top bit moves into the partial remainder each step
   data_t            quo_q;
   data_t            rem_q;
   data_t            divisor_q;
   tag_t             tag_q;

   logic [W:0]       trial;
   logic [W:0]       diff;
   logic             take;

   // one operation at a time, nothing is taken until the result has left
   assign issue_accept = (state_q == ST_IDLE);
   assign start        = issue_valid && issue_accept;

   // restoring step, the subtraction is kept only when it does not borrow
   // with a zero divisor every step subtracts, which leaves all ones
   always_comb begin
      trial = {rem_q, quo_q[W-1]};
      diff  = trial - {1'b0, divisor_q};
      take  = (trial >= {1'b0, divisor_q});
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= ST_IDLE;
         step_q  <= '0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (start) begin
                  state_q <= ST_BUSY;
                  step_q  <= '0;
               end
            end
            ST_BUSY: begin
               step_q <= step_q + CNT_W'(1);
               if (step_q == LAST_STEP) begin
                  state_q <= ST_DONE;
               end
            end
            ST_DONE: begin
               if (result_grant) begin
                  state_q <= ST_IDLE;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         quo_q     <= issue_rsdata;
         rem_q     <= '0;
         divisor_q <= issue_rtdata;
         tag_q     <= issue_rdtag;
      end else if (state_q == ST_BUSY) begin
         quo_q <= {quo_q[W-2:0], take};
         rem_q <= take ? diff[W-1:0] : trial[W-1:0];
      end
   end

   assign result_valid = (state_q == ST_DONE);
   assign result_tag   = tag_q;
   assign result_data  = quo_q;

   // a busy divider can only move on to done, never straight back to accepting
   a_no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
      state_q == ST_BUSY |=> !issue_accept)
      else $error("div_unit: accept while busy");

endmodule

/* hw/cdb_arbiter.sv */
`timescale 1ns/10ps

module cdb_arbiter
   import muldiv_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  mul_valid,
   input  tag_t  mul_tag,
   input  data_t mul_data,
   input  logic  div_valid,
   input  tag_t  div_tag,
   input  data_t div_data,
   output logic  mul_grant,
   output logic  div_grant,
   output logic  cdb_valid,
   output tag_t  cdb_tag,
   output data_t cdb_data
);

   // set when the divider won the most recent grant
   logic last_div_q;

   // with both units asking, the one that lost last time goes first
   assign mul_grant = mul_valid && (!div_valid || last_div_q);
   assign div_grant = div_valid && (!mul_valid || !last_div_q);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_div_q <= 1'b0;
         cdb_valid  <= 1'b0;
      end else begin
         if (mul_grant || div_grant) begin
            last_div_q <= div_grant;
         end
         cdb_valid <= mul_grant || div_grant;
      end
   end

   // the winner shows up on the CDB one cycle after its grant
   always_ff @(posedge clk) begin
      if (div_grant) begin
         cdb_tag  <= div_tag;
         cdb_data <= div_data;
      end else if (mul_grant) begin
         cdb_tag  <= mul_tag;
         cdb_data <= mul_data;
      end
   end

   a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({mul_grant, div_grant}))
      else $error("cdb_arbiter: two grants at once");

endmodule

/* hw/muldiv_cluster.sv */
`timescale 1ns/10ps

module muldiv_cluster
   import muldiv_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  muldiv_op_t dispatch_op,
   input  tag_t       dispatch_rdtag,
   input  tag_t       dispatch_rstag,
   input  tag_t       dispatch_rttag,
   input  data_t      dispatch_rsdata,
   input  data_t      dispatch_rtdata,
   input  logic       dispatch_rsvalid,
   input  logic       dispatch_rtvalid,
   input  logic       dispatch_en,
   output logic       dispatch_ready,
   output logic       cdb_valid,
   output tag_t       cdb_tag,
   output data_t      cdb_data
);

   logic  mul_en;
   logic  mul_ready;
   logic  mul_issue_valid;
   tag_t  mul_issue_rdtag;
   data_t mul_issue_rsdata;
   data_t mul_issue_rtdata;
   logic  mul_issue_accept;
   logic  mul_result_valid;
   tag_t  mul_result_tag;
   data_t mul_result_data;
   logic  mul_grant;

   logic  div_en;
   logic  div_ready;
   logic  div_issue_valid;
   tag_t  div_issue_rdtag;
   data_t div_issue_rsdata;
   data_t div_issue_rtdata;
   logic  div_issue_accept;
   logic  div_result_valid;
   tag_t  div_result_tag;
   data_t div_result_data;
   logic  div_grant;

   // only the queue of the selected class sees the dispatch
   // and only in a cycle where that queue can take it
   assign mul_en         = dispatch_en && (dispatch_op == OP_MUL) && mul_ready;
   assign div_en         = dispatch_en && (dispatch_op == OP_DIV) && div_ready;
   assign dispatch_ready = (dispatch_op == OP_MUL) ? mul_ready : div_ready;

   // both queues snoop the same CDB that leaves the cluster
   exec_queue mul_queue (
      .clk, .rst_n,
      .rdtag(dispatch_rdtag), .rstag(dispatch_rstag), .rttag(dispatch_rttag),
      .rsdata(dispatch_rsdata), .rtdata(dispatch_rtdata),
      .rsvalid(dispatch_rsvalid), .rtvalid(dispatch_rtvalid),
      .en(mul_en), .ready(mul_ready),
      .cdb_valid, .cdb_tag, .cdb_data,
      .issue_valid(mul_issue_valid), .issue_rdtag(mul_issue_rdtag),
      .issue_rsdata(mul_issue_rsdata), .issue_rtdata(mul_issue_rtdata),
      .issue_accept(mul_issue_accept)
   );

   exec_queue div_queue (
      .clk, .rst_n,
      .rdtag(dispatch_rdtag), .rstag(dispatch_rstag), .rttag(dispatch_rttag),
      .rsdata(dispatch_rsdata), .rtdata(dispatch_rtdata),
      .rsvalid(dispatch_rsvalid), .rtvalid(dispatch_rtvalid),
      .en(div_en), .ready(div_ready),
      .cdb_valid, .cdb_tag, .cdb_data,
      .issue_valid(div_issue_valid), .issue_rdtag(div_issue_rdtag),
      .issue_rsdata(div_issue_rsdata), .issue_rtdata(div_issue_rtdata),
      .issue_accept(div_issue_accept)
   );

   mul_unit u_mul_unit (
      .clk, .rst_n,
      .issue_valid(mul_issue_valid), .issue_rdtag(mul_issue_rdtag),
      .issue_rsdata(mul_issue_rsdata), .issue_rtdata(mul_issue_rtdata),
      .issue_accept(mul_issue_accept),
      .result_valid(mul_result_valid), .result_tag(mul_result_tag),
      .result_data(mul_result_data), .result_grant(mul_grant)
   );

   div_unit u_div_unit (
      .clk, .rst_n,
      .issue_valid(div_issue_valid), .issue_rdtag(div_issue_rdtag),
      .issue_rsdata(div_issue_rsdata), .issue_rtdata(div_issue_rtdata),
      .issue_accept(div_issue_accept),
      .result_valid(div_result_valid), .result_tag(div_result_tag),
      .result_data(div_result_data), .result_grant(div_grant)
   );

   cdb_arbiter u_cdb_arbiter (
      .clk, .rst_n,
      .mul_valid(mul_result_valid), .mul_tag(mul_result_tag), .mul_data(mul_result_data),
      .div_valid(div_result_valid), .div_tag(div_result_tag), .div_data(div_result_data),
      .mul_grant, .div_grant,
      .cdb_valid, .cdb_tag, .cdb_data
   );

endmodule

/* sim/tb_muldiv_model.svh */
`ifndef TB_MULDIV_MODEL_SVH
`define TB_MULDIV_MODEL_SVH

localparam int NUM_TAGS = 1 << `MULDIV_TAG_W;
localparam int DW       = `MULDIV_DATA_W;

// one row per tag, live while the instruction holding that tag is in flight
bit          pending  [NUM_TAGS];
muldiv_op_t  op_of    [NUM_TAGS];
int unsigned seq_of   [NUM_TAGS];
// a waiting operand names its producer, a resolved one holds its value
bit          rs_wait  [NUM_TAGS];
bit          rt_wait  [NUM_TAGS];
tag_t        rs_src   [NUM_TAGS];
tag_t        rt_src   [NUM_TAGS];
data_t       rs_val   [NUM_TAGS];
data_t       rt_val   [NUM_TAGS];
// the last value broadcast under each tag
data_t       last_val [NUM_TAGS];

int unsigned n_sent;
int unsigned n_done;
int unsigned n_same_cycle;
bit          saw_overtake;

// low word of the product, or the unsigned quotient with all ones for a zero divisor
function automatic data_t expected_result(muldiv_op_t op, data_t a, data_t b);
   logic [2*DW-1:0] full;
   full = {{DW{1'b0}}, a} * {{DW{1'b0}}, b};
   if (op == OP_MUL) begin
      return full[DW-1:0];
   end
   if (b == '0) begin
      return '1;
   end
   return a / b;
endfunction

task automatic stop_with_failure(input string why);
   $display("%s", why);
   $display("CHECKS FAILED");
   $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_value(input string what, input data_t got, input data_t want);
   if (got !== want) begin
      stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                  $time, what, got, want));
   end
endtask

// an operand named by tag either waits for its producer or, when the producer
// was broadcast in the dispatch cycle itself, takes that value right away
task automatic take_operand(input bit valid, input tag_t src, input data_t val,
                            output bit wait_o, output data_t val_o);
   wait_o = 1'b0;
   val_o  = val;
   if (!valid && pending[src]) begin
      wait_o = 1'b1;
   end else if (!valid) begin
      val_o = last_val[src];
      n_same_cycle++;
   end
endtask

task automatic record_dispatch(input muldiv_op_t op, input tag_t rd,
                               input bit rsv, input tag_t rst, input data_t rsd,
                               input bit rtv, input tag_t rtt, input data_t rtd);
   if (pending[rd]) begin
      stop_with_failure($sformatf("tag %0d was dispatched while still in flight", rd));
   end
   n_sent++;
   pending[rd] = 1'b1;
   op_of[rd]   = op;
   seq_of[rd]  = n_sent;
   rs_src[rd]  = rst;
   rt_src[rd]  = rtt;
   take_operand(rsv, rst, rsd, rs_wait[rd], rs_val[rd]);
   take_operand(rtv, rtt, rtd, rt_wait[rd], rt_val[rd]);
endtask

task automatic record_broadcast(input tag_t tag, input data_t data);
   if (!pending[tag]) begin
      stop_with_failure($sformatf("the CDB carried tag %0d, which is not in flight", tag));
   end else if (rs_wait[tag] || rt_wait[tag]) begin
      stop_with_failure($sformatf("tag %0d was broadcast before its operands", tag));
   end
   check_value($sformatf("cdb_data of tag %0d", tag), data,
               expected_result(op_of[tag], rs_val[tag], rt_val[tag]));
   pending[tag]  = 1'b0;
   last_val[tag] = data;
   n_done++;
   // wake every waiting operand that names this producer
   for (int i = 0; i < NUM_TAGS; i++) begin
      if (pending[i] && rs_wait[i] && rs_src[i] == tag) begin
         rs_wait[i] = 1'b0;
         rs_val[i]  = data;
      end
      if (pending[i] && rt_wait[i] && rt_src[i] == tag) begin
         rt_wait[i] = 1'b0;
         rt_val[i]  = data;
      end
      // a multiply finishing ahead of an older divide
      if (pending[i] && op_of[tag] == OP_MUL && op_of[i] == OP_DIV && seq_of[i] < seq_of[tag]) begin
         saw_overtake = 1'b1;
      end
   end
endtask

`endif

/* sim/tb_muldiv_cluster.sv */
`timescale 1ns/10ps
`include "muldiv_settings.svh"

module tb_muldiv_cluster
   import muldiv_pkg::*;
();

   localparam int NUM_INSTR   = 400;
   // each instruction gets 40 cycles, plus margin for reset and the final drain
   localparam int CYCLE_LIMIT = NUM_INSTR * 40 + 2000;

   logic       clk;
   logic       rst_n;
   muldiv_op_t dispatch_op;
   tag_t       dispatch_rdtag;
   tag_t       dispatch_rstag;
   tag_t       dispatch_rttag;
   data_t      dispatch_rsdata;
   data_t      dispatch_rtdata;
   logic       dispatch_rsvalid;
   logic       dispatch_rtvalid;
   logic       dispatch_en;
   logic       dispatch_ready;
   logic       cdb_valid;
   tag_t       cdb_tag;
   data_t      cdb_data;

   int unsigned cycles;
   int unsigned refused;

`include "tb_muldiv_model.svh"

   muldiv_cluster DUT (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // values lean toward small numbers so quotients are not almost always zero
   function automatic data_t random_value(bit divisor);
      int unsigned kind;
      kind = $urandom % 8;
      if (divisor && kind == 0) begin
         return '0;
      end
      if (kind < 3) begin
         return data_t'($urandom % 16);
      end
      if (kind < 5) begin
         return data_t'($urandom % 65536);
      end
      return data_t'($urandom);
   endfunction

   function automatic tag_t free_tag();
      int unsigned start;
      tag_t        probe;
      start = $urandom;
      for (int i = 0; i < NUM_TAGS; i++) begin
         probe = tag_t'(start + i);
         if (!pending[probe]) begin
            return probe;
         end
      end
      return '0;
   endfunction

   // with deps set, an operand may name a pending tag instead of carrying a value
   task automatic pick_operand(input bit divisor, input bit deps,
                               output logic valid, output tag_t tag, output data_t value);
      int unsigned start;
      tag_t        probe;
      valid = 1'b1;
      tag   = '0;
      value = random_value(divisor);
      if (deps && ($urandom % 2) == 0) begin
         if (cdb_valid && pending[cdb_tag] && ($urandom % 2) == 0) begin
            // the producer is on the CDB right now and must be caught at dispatch
            valid = 1'b0;
            tag   = cdb_tag;
         end else begin
            start = $urandom;
            for (int i = 0; i < NUM_TAGS; i++) begin
               probe = tag_t'(start + i);
               if (valid && pending[probe]) begin
                  valid = 1'b0;
                  tag   = probe;
               end
            end
         end
      end
   endtask

   // a refused instruction is drawn again, since its pending tags may retire meanwhile
   task automatic dispatch_one(input muldiv_op_t op, input bit deps);
      bit done;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         dispatch_op    = op;
         dispatch_rdtag = free_tag();
         pick_operand(1'b0, deps, dispatch_rsvalid, dispatch_rstag, dispatch_rsdata);
         pick_operand(op == OP_DIV, deps, dispatch_rtvalid, dispatch_rttag, dispatch_rtdata);
         dispatch_en = 1'b1;
         @(posedge clk);
         done = dispatch_ready;
      end
   endtask

   // the CDB is retired before the dispatch of the same cycle is recorded,
   // which matches the queue snooping the CDB for an incoming instruction
   always @(posedge clk) begin
      if (rst_n) begin
         if (n_sent == 0) begin
            check_value("cdb_valid before the first dispatch", data_t'(cdb_valid), '0);
         end
         if (cdb_valid) begin
            record_broadcast(cdb_tag, cdb_data);
         end
         if (dispatch_en && !dispatch_ready && dispatch_op == OP_DIV) begin
            refused++;
         end
         if (dispatch_en && dispatch_ready) begin
            record_dispatch(dispatch_op, dispatch_rdtag,
                            dispatch_rsvalid, dispatch_rstag, dispatch_rsdata,
                            dispatch_rtvalid, dispatch_rttag, dispatch_rtdata);
         end
      end
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d results back",
                                     cycles, n_done, n_sent));
      end
   end

   initial begin
      void'($urandom(32'h252b));
      rst_n            = 1'b0;
      dispatch_en      = 1'b0;
      dispatch_op      = OP_MUL;
      dispatch_rdtag   = '0;
      dispatch_rstag   = '0;
      dispatch_rttag   = '0;
      dispatch_rsdata  = '0;
      dispatch_rtdata  = '0;
      dispatch_rsvalid = 1'b0;
      dispatch_rtvalid = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      // a quiet stretch where the CDB has to stay idle
      repeat (5) @(negedge clk);

      // independent operations with value operands only
      repeat (120) dispatch_one(muldiv_op_t'($urandom % 2), 1'b0);
      // operands that wait on pending tags, some broadcast in the dispatch cycle
      repeat (200) dispatch_one(muldiv_op_t'($urandom % 2), 1'b1);
      // a divide burst that overruns the div queue
      repeat (40) dispatch_one(OP_DIV, 1'b0);
      // multiplies issued behind a long divide
      repeat (10) begin
         dispatch_one(OP_DIV, 1'b0);
         repeat (3) dispatch_one(OP_MUL, 1'b0);
      end
      @(negedge clk);
      dispatch_en = 1'b0;

      while (n_done != n_sent) begin
         @(posedge clk);
      end
      // any stray broadcast here names a tag that is no longer in flight
      repeat (50) @(posedge clk);

      check_value("instructions dispatched", data_t'(n_sent), data_t'(NUM_INSTR));
      check_value("results broadcast", data_t'(n_done), data_t'(n_sent));
      check_value("same cycle wakeups seen", data_t'(n_same_cycle != 0), data_t'(1));
      check_value("div dispatch refusals seen", data_t'(refused != 0), data_t'(1));
      check_value("multiply passed a divide", data_t'(saw_overtake), data_t'(1));
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* flist.f */
+incdir+hw
+incdir+sim
hw/muldiv_pkg.sv
hw/exec_queue.sv
hw/mul_unit.sv
hw/div_unit.sv
hw/cdb_arbiter.sv
hw/muldiv_cluster.sv
sim/tb_muldiv_cluster.sv

/* Makefile */
TOP = tb_muldiv_cluster
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the Verilator build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)
